// File: filelist.f
+incdir+src
src/butterfly_pkg.sv
src/butterfly_stage.sv
src/butterfly_decode.sv
src/butterfly_execute.sv
src/butterfly_result.sv
src/butterfly_harness.sv
verification/butterfly_sva.sv
verification/butterfly_tb.sv

// File: Makefile
# Verilator simulation of the butterfly engine.

VERILATOR ?= verilator
TOP       ?= butterfly_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/butterfly_tb.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_tb;

  typedef logic signed [`BFLY_WIDTH-1:0]   word_t;
  typedef logic signed [2*`BFLY_WIDTH-1:0] dword_t;
  typedef logic [`BFLY_IN_BITS-1:0]        in_msg_t;
  typedef logic [`BFLY_OUT_BITS-1:0]       out_msg_t;

  localparam int word_bits  = `BFLY_WIDTH;
  localparam int in_lane    = 6 * `BFLY_WIDTH;
  localparam int out_lane   = 4 * `BFLY_WIDTH;
  localparam int clk_period = 8;

  // Messages per test.
  localparam int n_ident = 8;
  localparam int n_rand  = 200;
  localparam int n_lat   = 1;
  localparam int n_bp    = 60;
  localparam int n_tp    = 16;
  localparam int total_msgs = n_ident + n_rand + n_lat + n_bp + n_tp;
  localparam int watchdog_cycles = total_msgs * 20 + 1000;

  logic     clk = 1'b0;
  logic     reset;
  logic     recv_val;
  logic     recv_rdy;
  in_msg_t  recv_msg;
  logic     send_val;
  logic     send_rdy;
  out_msg_t send_msg;

  // Scoreboard and per-test bookkeeping.
  out_msg_t exp_q[$];
  out_msg_t exp_msg;
  out_msg_t held_msg;
  logic     stalled = 1'b0;
  logic     exp_rdy;
  logic     bp_active = 1'b0;
  string    cur_test = "none";
  int       cycle = 0;
  int       errors = 0;
  int       test_start_errs = 0;
  int       tests_passed = 0;
  int       tests_failed = 0;
  int       out_count = 0;
  int       first_out = 0;
  int       last_out = 0;
  int       last_acc = 0;
  int       full_seen = 0;

  butterfly_harness DUT (
    .clk     (clk),
    .reset   (reset),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .recv_msg(recv_msg),
    .send_val(send_val),
    .send_rdy(send_rdy),
    .send_msg(send_msg)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Random output stall, mostly low so the pipeline fills up.
  always @(negedge clk) begin
    if (bp_active) begin
      send_rdy = ($urandom_range(3, 0) == 0);
    end
  end

  // Reference butterfly built from the fixed-point rules of the format.
  function automatic out_msg_t butterfly_model(input in_msg_t msg);
    out_msg_t out;
    word_t    ar, ai, br, bi, wr, wi;
    dword_t   prr, pii, pri, pir;
    word_t    tr, ti;
    out = '0;
    for (int i = 0; i < `BFLY_LANES; i++) begin
      ar = msg[i*in_lane + 5*word_bits +: word_bits];
      ai = msg[i*in_lane + 4*word_bits +: word_bits];
      br = msg[i*in_lane + 3*word_bits +: word_bits];
      bi = msg[i*in_lane + 2*word_bits +: word_bits];
      wr = msg[i*in_lane + 1*word_bits +: word_bits];
      wi = msg[i*in_lane +: word_bits];
      // Exact double width products, then floor division by 2^frac.
      prr = (dword_t'(wr) * dword_t'(br)) >>> `BFLY_FRAC;
      pii = (dword_t'(wi) * dword_t'(bi)) >>> `BFLY_FRAC;
      pri = (dword_t'(wr) * dword_t'(bi)) >>> `BFLY_FRAC;
      pir = (dword_t'(wi) * dword_t'(br)) >>> `BFLY_FRAC;
      tr = word_t'(prr) - word_t'(pii);
      ti = word_t'(pri) + word_t'(pir);
      out[i*out_lane +: out_lane] = {word_t'(ar + tr), word_t'(ai + ti),
                                     word_t'(ar - tr), word_t'(ai - ti)};
    end
    return out;
  endfunction

  function automatic in_msg_t random_msg();
    in_msg_t msg;
    for (int k = 0; k < 6 * `BFLY_LANES; k++) begin
      msg[k*word_bits +: word_bits] = $urandom();
    end
    return msg;
  endfunction

  // Words near the ends of the range, to force product and sum overflow.
  function automatic in_msg_t extreme_msg();
    in_msg_t msg;
    word_t   word;
    for (int k = 0; k < 6 * `BFLY_LANES; k++) begin
      case ($urandom_range(3, 0))
        0: word = {1'b1, {(word_bits-1){1'b0}}};
        1: word = {1'b0, {(word_bits-1){1'b1}}};
        2: word = '1;
        default: word = $urandom();
      endcase
      msg[k*word_bits +: word_bits] = word;
    end
    return msg;
  endfunction

  // Output monitor and input recorder, one process so the order is fixed.
  always @(posedge clk) begin
    if (reset) begin
      stalled = 1'b0;
    end else begin
      exp_rdy = !(exp_q.size() == 3 && !send_rdy);
      assert (recv_rdy == exp_rdy) else begin
        $display("FAIL %s: recv_rdy expected %0b, actual %0b", cur_test, exp_rdy, recv_rdy);
        errors++;
      end
      if (!recv_rdy) full_seen++;
      if (stalled) begin
        assert (send_val && send_msg == held_msg) else begin
          $display("%s: output changed while send_rdy was low", cur_test);
          errors++;
        end
      end
      if (send_val && send_rdy) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: output message arrived with nothing expected", cur_test);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_msg = exp_q.pop_front();
          assert (send_msg == exp_msg) else begin
            $display("FAIL %s: send_msg expected %h, actual %h", cur_test, exp_msg, send_msg);
            errors++;
          end
        end
        if (out_count == 0) first_out = cycle;
        last_out = cycle;
        out_count++;
      end
      if (recv_val && recv_rdy) begin
        exp_q.push_back(butterfly_model(recv_msg));
        last_acc = cycle;
      end
      stalled = send_val && !send_rdy;
      held_msg = send_msg;
    end
  end

  task automatic report_mismatch(input string what, input out_msg_t exp, input out_msg_t act);
    $display("FAIL %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance.
  task automatic drive_msg(input in_msg_t msg);
    recv_val = 1'b1;
    recv_msg = msg;
    @(posedge clk);
    while (!recv_rdy) @(posedge clk);
    @(negedge clk);
    recv_val = 1'b0;
  endtask

  task automatic wait_drain(input int n_msgs);
    int limit;
    limit = n_msgs * 20 + 50;
    for (int i = 0; i < limit && exp_q.size() != 0; i++) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      $display("%s: timed out with %0d expected messages never sent", cur_test, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_start_errs = errors;
    out_count = 0;
  endtask

  task automatic report_test(input int n_msgs);
    int n_err;
    n_err = errors - test_start_errs;
    if (n_err == 0) tests_passed++;
    else tests_failed++;
    $display("%-16s %s  messages %0d  errors %0d", cur_test, (n_err == 0) ? "ok" : "bad",
             n_msgs, n_err);
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    assert (send_val == 1'b0) else report_mismatch("send_val", out_msg_t'(0), out_msg_t'(send_val));
    assert (recv_rdy == 1'b1) else report_mismatch("recv_rdy", out_msg_t'(1), out_msg_t'(recv_rdy));
    report_test(0);
  endtask

  // w = 1.0 + 0j in every lane, so c = a + b and d = a - b.
  task automatic identity_twiddle();
    in_msg_t msg;
    begin_test("identity_twiddle");
    for (int j = 0; j < n_ident; j++) begin
      msg = random_msg();
      for (int i = 0; i < `BFLY_LANES; i++) begin
        msg[i*in_lane +: word_bits] = '0;
        msg[i*in_lane + word_bits +: word_bits] = word_t'(1) <<< `BFLY_FRAC;
      end
      drive_msg(msg);
    end
    wait_drain(n_ident);
    report_test(n_ident);
  endtask

  task automatic random_operands();
    begin_test("random_operands");
    for (int j = 0; j < n_rand; j++) begin
      drive_msg((j % 8 == 0) ? extreme_msg() : random_msg());
    end
    wait_drain(n_rand);
    report_test(n_rand);
  endtask

  task automatic fixed_latency();
    begin_test("fixed_latency");
    drive_msg(random_msg());
    wait_drain(n_lat);
    assert (last_out - last_acc == 3)
      else report_mismatch("latency", out_msg_t'(3), out_msg_t'(last_out - last_acc));
    report_test(n_lat);
  endtask

  task automatic back_pressure();
    begin_test("back_pressure");
    full_seen = 0;
    bp_active = 1'b1;
    for (int j = 0; j < n_bp; j++) begin
      drive_msg(random_msg());
    end
    bp_active = 1'b0;
    send_rdy = 1'b1;
    wait_drain(n_bp);
    assert (out_count == n_bp)
      else report_mismatch("output count", out_msg_t'(n_bp), out_msg_t'(out_count));
    assert (full_seen > 0) else begin
      $display("%s: recv_rdy never dropped, the pipeline never filled", cur_test);
      errors++;
    end
    report_test(n_bp);
  endtask

  task automatic throughput();
    begin_test("throughput");
    for (int j = 0; j < n_tp; j++) begin
      drive_msg(random_msg());
    end
    wait_drain(n_tp);
    assert (out_count == n_tp)
      else report_mismatch("output count", out_msg_t'(n_tp), out_msg_t'(out_count));
    assert (last_out - first_out == n_tp - 1)
      else report_mismatch("output span", out_msg_t'(n_tp - 1), out_msg_t'(last_out - first_out));
    report_test(n_tp);
  endtask

  initial begin
    void'($urandom(32'hc538));
    reset = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    send_rdy = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    reset_state();
    identity_twiddle();
    random_operands();
    fixed_latency();
    back_pressure();
    throughput();

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Bound on the whole run, from the message count of all tests.
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog: run went past %0d cycles without finishing", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: verification/butterfly_sva.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_sva (
  input logic                      clk,
  input logic                      reset,
  input logic                      recv_rdy,
  input logic                      send_val,
  input logic                      send_rdy,
  input logic [`BFLY_OUT_BITS-1:0] send_msg
);

  // A stalled output keeps its valid and its message.
  send_hold: assert property (
    @(posedge clk) disable iff (reset)
    send_val && !send_rdy |=> send_val && $stable(send_msg)
  ) else $error("send_val or send_msg changed while send_rdy was low");

  // Output register is empty right after reset.
  reset_empty: assert property (
    @(posedge clk) reset |=> !send_val
  ) else $error("send_val high in the cycle after reset");

  ready_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(recv_rdy)
  ) else $error("recv_rdy is unknown");

endmodule

bind butterfly_harness butterfly_sva u_sva (
  .clk     (clk),
  .reset   (reset),
  .recv_rdy(recv_rdy),
  .send_val(send_val),
  .send_rdy(send_rdy),
  .send_msg(send_msg)
);

// File: src/butterfly_harness.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_harness (
  input  logic                      clk,
  input  logic                      reset,

  input  logic                      recv_val,
  output logic                      recv_rdy,
  input  logic [`BFLY_IN_BITS-1:0]  recv_msg,

  output logic                      send_val,
  input  logic                      send_rdy,
  output logic [`BFLY_OUT_BITS-1:0] send_msg
);

  import butterfly_pkg::*;

  // Decode to execute.
  logic         dec_val;
  logic         dec_rdy;
  operand_vec_t dec_ops;

  // Execute to result.
  logic         exe_val;
  logic         exe_rdy;
  result_vec_t  exe_res;

  butterfly_decode u_decode (
    .clk     (clk),
    .reset   (reset),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .recv_msg(recv_msg),
    .dec_val (dec_val),
    .dec_rdy (dec_rdy),
    .dec_ops (dec_ops)
  );

  butterfly_execute u_execute (
    .clk    (clk),
    .reset  (reset),
    .dec_val(dec_val),
    .dec_rdy(dec_rdy),
    .dec_ops(dec_ops),
    .exe_val(exe_val),
    .exe_rdy(exe_rdy),
    .exe_res(exe_res)
  );

  butterfly_result u_result (
    .clk     (clk),
    .reset   (reset),
    .exe_val (exe_val),
    .exe_rdy (exe_rdy),
    .exe_res (exe_res),
    .send_val(send_val),
    .send_rdy(send_rdy),
    .send_msg(send_msg)
  );

endmodule

// File: src/butterfly_result.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_result (
  input  logic                       clk,
  input  logic                       reset,

  input  logic                       exe_val,
  output logic                       exe_rdy,
  input  butterfly_pkg::result_vec_t exe_res,

  output logic                       send_val,
  input  logic                       send_rdy,
  output logic [`BFLY_OUT_BITS-1:0]  send_msg
);

  import butterfly_pkg::*;

  localparam int lane_bits = 4 * `BFLY_WIDTH;

  logic [`BFLY_OUT_BITS-1:0] send_next;

  for (genvar i = 0; i < `BFLY_LANES; i++) begin : g_lane
    bfly_result_t lane_res;

    assign lane_res = exe_res[i];

    // Top of the lane is c.re, then c.im, d.re, d.im.
    assign send_next[i*lane_bits +: lane_bits] = {
      lane_res.c.re, lane_res.c.im, lane_res.d.re, lane_res.d.im
    };
  end

  // Output register faces the outside, so send_msg holds under back-pressure.
  butterfly_stage #(
    .payload_t(logic [`BFLY_OUT_BITS-1:0])
  ) u_stage (
    .clk     (clk),
    .reset   (reset),
    .in_val  (exe_val),
    .in_rdy  (exe_rdy),
    .in_data (send_next),
    .out_val (send_val),
    .out_rdy (send_rdy),
    .out_data(send_msg)
  );

endmodule

// File: src/butterfly_execute.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_execute (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        dec_val,
  output logic                        dec_rdy,
  input  butterfly_pkg::operand_vec_t dec_ops,

  output logic                        exe_val,
  input  logic                        exe_rdy,
  output butterfly_pkg::result_vec_t  exe_res
);

  import butterfly_pkg::*;

  localparam int prod_bits = 2 * `BFLY_WIDTH;

  result_vec_t exe_next;

  for (genvar i = 0; i < `BFLY_LANES; i++) begin : g_lane
    bfly_operand_t                op;

    // Full width products of twiddle and b.
    logic signed [prod_bits-1:0]  p_rr;
    logic signed [prod_bits-1:0]  p_ii;
    logic signed [prod_bits-1:0]  p_ri;
    logic signed [prod_bits-1:0]  p_ir;

    // Products after the fraction shift.
    logic signed [prod_bits-1:0]  s_rr;
    logic signed [prod_bits-1:0]  s_ii;
    logic signed [prod_bits-1:0]  s_ri;
    logic signed [prod_bits-1:0]  s_ir;

    // Products truncated back to one word.
    word_t                        q_rr;
    word_t                        q_ii;
    word_t                        q_ri;
    word_t                        q_ir;

    cplx_t                        t;
    bfly_result_t                 res;

    assign op = dec_ops[i];

    // Signed operands keep the multiply signed at double width.
    assign p_rr = $signed(op.w.re) * $signed(op.b.re);
    assign p_ii = $signed(op.w.im) * $signed(op.b.im);
    assign p_ri = $signed(op.w.re) * $signed(op.b.im);
    assign p_ir = $signed(op.w.im) * $signed(op.b.re);

    // Arithmetic shift, so negative products round toward minus infinity.
    assign s_rr = p_rr >>> `BFLY_FRAC;
    assign s_ii = p_ii >>> `BFLY_FRAC;
    assign s_ri = p_ri >>> `BFLY_FRAC;
    assign s_ir = p_ir >>> `BFLY_FRAC;

    assign q_rr = word_t'(s_rr);
    assign q_ii = word_t'(s_ii);
    assign q_ri = word_t'(s_ri);
    assign q_ir = word_t'(s_ir);

    // t = w * b, sums wrap at the word width.
    assign t.re = q_rr - q_ii;
    assign t.im = q_ri + q_ir;

    assign res.c.re = op.a.re + t.re;
    assign res.c.im = op.a.im + t.im;
    assign res.d.re = op.a.re - t.re;
    assign res.d.im = op.a.im - t.im;

    assign exe_next[i] = res;
  end

  butterfly_stage #(
    .payload_t(result_vec_t)
  ) u_stage (
    .clk     (clk),
    .reset   (reset),
    .in_val  (dec_val),
    .in_rdy  (dec_rdy),
    .in_data (exe_next),
    .out_val (exe_val),
    .out_rdy (exe_rdy),
    .out_data(exe_res)
  );

endmodule

// File: src/butterfly_decode.sv
`timescale 1ns/10ps
`include "butterfly_defines.svh"

module butterfly_decode (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        recv_val,
  output logic                        recv_rdy,
  input  logic [`BFLY_IN_BITS-1:0]    recv_msg,

  output logic                        dec_val,
  input  logic                        dec_rdy,
  output butterfly_pkg::operand_vec_t dec_ops
);

  import butterfly_pkg::*;

  localparam int lane_bits = 6 * `BFLY_WIDTH;
  localparam int w = `BFLY_WIDTH;

  operand_vec_t dec_next;

  for (genvar i = 0; i < `BFLY_LANES; i++) begin : g_lane
    logic [lane_bits-1:0] lane_msg;
    bfly_operand_t        lane_op;

    assign lane_msg = recv_msg[i*lane_bits +: lane_bits];

    // Fields from the top: a.re, a.im, b.re, b.im, w.re, w.im.
    assign lane_op.a.re = lane_msg[5*w +: w];
    assign lane_op.a.im = lane_msg[4*w +: w];
    assign lane_op.b.re = lane_msg[3*w +: w];
    assign lane_op.b.im = lane_msg[2*w +: w];
    assign lane_op.w.re = lane_msg[1*w +: w];
    assign lane_op.w.im = lane_msg[0 +: w];

    assign dec_next[i] = lane_op;
  end

  butterfly_stage #(
    .payload_t(operand_vec_t)
  ) u_stage (
    .clk     (clk),
    .reset   (reset),
    .in_val  (recv_val),
    .in_rdy  (recv_rdy),
    .in_data (dec_next),
    .out_val (dec_val),
    .out_rdy (dec_rdy),
    .out_data(dec_ops)
  );

endmodule

// File: src/butterfly_stage.sv
`timescale 1ns/10ps

module butterfly_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_data,

  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_data
);

  logic in_fire;

  // Room for a new payload when empty or when the held one leaves now.
  assign in_rdy  = !out_val || out_rdy;
  assign in_fire = in_val && in_rdy;

  // Valid follows the input whenever the register can advance.
  // An output transfer with no new input leaves the register empty.
  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (in_rdy) begin
      out_val <= in_val;
    end
  end

  // Payload only changes on an accepted input.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_data <= in_data;
    end
  end

endmodule

// File: src/butterfly_pkg.sv
`include "butterfly_defines.svh"

package butterfly_pkg;

  // One signed real word.
  typedef logic signed [`BFLY_WIDTH-1:0] word_t;

  // Complex value, real part in the upper word.
  typedef struct packed {
    word_t re;
    word_t im;
  } cplx_t;

  // Operands of one butterfly.
  // Field order matches the flat lane layout, a in the top bits.
  typedef struct packed {
    cplx_t a;
    cplx_t b;
    cplx_t w;
  } bfly_operand_t;

  // Outputs of one butterfly, c = a + w*b and d = a - w*b.
  typedef struct packed {
    cplx_t c;
    cplx_t d;
  } bfly_result_t;

  // Lane 0 sits in the least significant position.
  typedef bfly_operand_t [`BFLY_LANES-1:0] operand_vec_t;

  typedef bfly_result_t [`BFLY_LANES-1:0] result_vec_t;

endpackage

// File: src/butterfly_defines.svh
`ifndef BUTTERFLY_DEFINES_SVH
`define BUTTERFLY_DEFINES_SVH

// Bits in one real two's complement word.
`define BFLY_WIDTH 32

// Fraction bits of the fixed-point format.
`define BFLY_FRAC 16

// Independent butterflies carried in one message.
`define BFLY_LANES 4

// Input lane is a, b and w, six words in all.
`define BFLY_IN_BITS (6 * `BFLY_WIDTH * `BFLY_LANES)

// Output lane is c and d, four words in all.
`define BFLY_OUT_BITS (4 * `BFLY_WIDTH * `BFLY_LANES)

`endif
